// File: design/kronos_pkg.sv
// --------------------------------------
// Kronos ID stage shared widths, opcode and ALU encodings
// --------------------------------------
package kronos_pkg;

    // Data and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Constant operands
    localparam logic [XLEN-1:0] FOUR = 32'd4;
    localparam logic [XLEN-1:0] ZERO = 32'd0;

    // --------------------------------------
    // RV32I major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        OP_LOAD  = 5'b00000,
        OP_OPIMM = 5'b00100,
        OP_AUIPC = 5'b00101,
        OP_STORE = 5'b01000,
        OP_OP    = 5'b01100,
        OP_LUI   = 5'b01101,
        OP_BR    = 5'b11000,
        OP_JALR  = 5'b11001,
        OP_JAL   = 5'b11011
    } opcode_e;

    // ALU result select
    typedef enum logic [2:0] {
        ALU_ADDER = 3'd0,
        ALU_AND   = 3'd1,
        ALU_OR    = 3'd2,
        ALU_XOR   = 3'd3,
        ALU_COMP  = 3'd4,
        ALU_SHIFT = 3'd5
    } alu_sel_e;

    // --------------------------------------
    // Execute stage controls, 9 bits
    typedef struct packed {
        logic     cin;   // Carry in, subtract
        logic     rev;   // Bit reverse for left shift
        logic     uns;   // Unsigned compare / logical shift
        logic     eq;    // Equality compare
        logic     inv;   // Invert compare result
        logic     align; // Clear sum bit 0
        alu_sel_e sel;
    } ex_ctrl_t;

endpackage

// File: design/rf_read_if.sv
// --------------------------------------
// Two-port register file read bundle
// --------------------------------------
`timescale 1ns/1ps

interface rf_read_if;
    import kronos_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // Decode side drives the indices
    modport requester (output rs1_addr, rs2_addr, input rs1_data, rs2_data);

    // Register array answers with data
    modport regfile (input rs1_addr, rs2_addr, output rs1_data, rs2_data);

endinterface

// File: design/kronos_regfile.sv
// --------------------------------------
// Integer register file, 32x32, x0 hardwired to zero
// --------------------------------------
`timescale 1ns/1ps

module kronos_regfile (
    input  logic                              clk,
    rf_read_if.regfile                        rd_port,
    input  logic                              wr_en,
    input  logic [kronos_pkg::REG_ADDR_W-1:0] wr_sel,
    input  logic [kronos_pkg::XLEN-1:0]       wr_data
);
    import kronos_pkg::*;

    // Flop array, contents undefined until written
    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // --------------------------------------
    // Combinational reads

    assign rd_port.rs1_data = (rd_port.rs1_addr != '0) ? regs[rd_port.rs1_addr]
                                                       : ZERO; // x0 reads zero
    assign rd_port.rs2_data = (rd_port.rs2_addr != '0) ? regs[rd_port.rs2_addr]
                                                       : ZERO;

    // --------------------------------------
    // Single write port

    // Writes to x0 land in the array but are masked on read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

// File: design/kronos_imm_decode.sv
// --------------------------------------
// Immediate decoder for I, S, B, U and J formats
// --------------------------------------
`timescale 1ns/1ps

module kronos_imm_decode (
    input  logic [kronos_pkg::XLEN-1:0] ir,
    output logic [kronos_pkg::XLEN-1:0] immediate
);
    import kronos_pkg::*;

    opcode_e opcode;
    logic    sign;
    logic    fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;

    // Immediate segments, LSB first
    logic        seg_a; // [0]
    logic [3:0]  seg_b; // [4:1]
    logic [5:0]  seg_c; // [10:5]
    logic        seg_d; // [11]
    logic [7:0]  seg_e; // [19:12]
    logic [11:0] seg_f; // [31:20]

    assign opcode = opcode_e'(ir[6:2]);
    assign sign   = ir[31]; // Every format signs from bit 31

    // Format classes
    assign fmt_i = opcode inside {OP_OPIMM, OP_JALR, OP_LOAD};
    assign fmt_s = (opcode == OP_STORE);
    assign fmt_b = (opcode == OP_BR);
    assign fmt_u = opcode inside {OP_LUI, OP_AUIPC};
    assign fmt_j = (opcode == OP_JAL);

    always_comb begin
        // Bit 0 exists only in I and S
        seg_a = fmt_i ? ir[20] : (fmt_s ? ir[7] : 1'b0);

        if (fmt_u)              seg_b = 4'b0;
        else if (fmt_i || fmt_j) seg_b = ir[24:21];
        else                    seg_b = ir[11:8]; // S and B

        seg_c = fmt_u ? 6'b0 : ir[30:25];

        // Bit 11 moves around the most
        if (fmt_u)      seg_d = 1'b0;
        else if (fmt_b) seg_d = ir[7];
        else if (fmt_j) seg_d = ir[20];
        else            seg_d = sign;

        seg_e = (fmt_u || fmt_j) ? ir[19:12] : {8{sign}};
        seg_f = fmt_u ? ir[31:20] : {12{sign}}; // U fills upper 20 bits
    end

    assign immediate = {seg_f, seg_e, seg_d, seg_c, seg_b, seg_a};

endmodule

// File: design/kronos_ex_decode.sv
// --------------------------------------
// Execute control decode and illegal instruction check
// --------------------------------------
`timescale 1ns/1ps

module kronos_ex_decode (
    input  logic [kronos_pkg::XLEN-1:0] ir,
    output kronos_pkg::ex_ctrl_t        ex_ctrl,
    output logic                        is_illegal
);
    import kronos_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;     // 0100000, SUB and SRA forms
    logic       instr_valid;

    assign opcode  = opcode_e'(ir[6:2]);
    assign funct3  = ir[14:12];
    assign funct7  = ir[31:25];
    assign f7_zero = (funct7 == 7'd0);
    assign f7_alt  = (funct7 == 7'd32);

    always_comb begin
        // Default is a plain add
        ex_ctrl     = '{cin: 1'b0, rev: 1'b0, uns: 1'b0, eq: 1'b0,
                        inv: 1'b0, align: 1'b0, sel: ALU_ADDER};
        instr_valid = 1'b0;

        case (opcode)
            OP_LUI, OP_AUIPC, OP_JAL: instr_valid = 1'b1;

            OP_JALR: begin
                ex_ctrl.align = 1'b1;           // Target LSB cleared
                instr_valid   = (funct3 == 3'b000);
            end

            // --------------------------------------
            OP_BR: begin
                ex_ctrl.sel = ALU_COMP;
                ex_ctrl.eq  = ~funct3[2];             // BEQ, BNE
                ex_ctrl.cin = funct3[2];              // BLT(U), BGE(U)
                ex_ctrl.uns = funct3[2] & funct3[1];  // BLTU, BGEU
                ex_ctrl.inv = funct3[0];              // BNE, BGE, BGEU
                instr_valid = (funct3 != 3'b010) && (funct3 != 3'b011);
            end

            OP_LOAD: begin
                // LB LH LW LBU LHU
                instr_valid = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end

            OP_STORE: instr_valid = funct3 inside {3'b000, 3'b001, 3'b010};

            // --------------------------------------
            // Register and immediate ALU ops share funct3 decode
            OP_OPIMM, OP_OP: begin
                case (funct3)
                    3'b000: ex_ctrl.cin = (opcode == OP_OP) & f7_alt; // SUB
                    3'b001: begin                       // SLL
                        ex_ctrl.rev = 1'b1;
                        ex_ctrl.uns = 1'b1;
                        ex_ctrl.sel = ALU_SHIFT;
                    end
                    3'b010: begin                       // SLT
                        ex_ctrl.cin = 1'b1;
                        ex_ctrl.sel = ALU_COMP;
                    end
                    3'b011: begin                       // SLTU
                        ex_ctrl.cin = 1'b1;
                        ex_ctrl.uns = 1'b1;
                        ex_ctrl.sel = ALU_COMP;
                    end
                    3'b100: ex_ctrl.sel = ALU_XOR;
                    3'b101: begin                       // SRL, SRA
                        ex_ctrl.uns = ~f7_alt;
                        ex_ctrl.sel = ALU_SHIFT;
                    end
                    3'b110: ex_ctrl.sel = ALU_OR;
                    default: ex_ctrl.sel = ALU_AND;
                endcase

                // Legal funct7 per form
                if (opcode == OP_OP)
                    instr_valid = f7_zero || (f7_alt && funct3 inside {3'b000, 3'b101});
                else if (funct3 == 3'b001)
                    instr_valid = f7_zero;              // SLLI
                else if (funct3 == 3'b101)
                    instr_valid = f7_zero || f7_alt;    // SRLI, SRAI
                else
                    instr_valid = 1'b1;                 // funct7 is immediate
            end

            default: instr_valid = 1'b0; // SYSTEM, MISC-MEM and unknown
        endcase
    end

    assign is_illegal = ~instr_valid | (ir[1:0] != 2'b11);

endmodule

// File: design/kronos_id_ctrl.sv
// --------------------------------------
// ID stage handshake, operand select and output register
// --------------------------------------
`timescale 1ns/1ps

module kronos_id_ctrl (
    input  logic                              clk,
    input  logic                              rstz,
    input  logic                              flush,
    input  logic [kronos_pkg::XLEN-1:0]       ir,
    input  logic [kronos_pkg::XLEN-1:0]       pc,
    input  logic                              in_valid,
    output logic                              in_ready,
    rf_read_if.requester                      rd_port,
    input  logic [kronos_pkg::XLEN-1:0]       immediate,
    input  kronos_pkg::ex_ctrl_t              ex_ctrl_in,
    input  logic                              illegal_in,
    output logic [kronos_pkg::XLEN-1:0]       op1,
    output logic [kronos_pkg::XLEN-1:0]       op2,
    output logic [kronos_pkg::XLEN-1:0]       op3,
    output logic [kronos_pkg::XLEN-1:0]       op4,
    output kronos_pkg::ex_ctrl_t              ex_ctrl,
    output logic [kronos_pkg::REG_ADDR_W-1:0] rd,
    output logic                              rd_write,
    output logic                              branch,
    output logic                              branch_cond,
    output logic                              ld,
    output logic                              st,
    output logic [2:0]                        funct3,
    output logic                              is_illegal,
    output logic                              out_valid,
    input  logic                              out_ready
);
    import kronos_pkg::*;

    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  accept;
    logic [XLEN-1:0]       op1_d, op2_d, op3_d, op4_d;

    assign opcode   = opcode_e'(ir[6:2]);
    assign rd_addr  = ir[11:7];

    assign rd_port.rs1_addr = ir[19:15];
    assign rd_port.rs2_addr = ir[24:20];

    // --------------------------------------
    // Handshake, one item held at most
    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready & ~flush; // Flush drops the offer

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;      // Back to back when drained same edge
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // --------------------------------------
    // Operand select
    always_comb begin
        op1_d = pc;
        op2_d = FOUR;
        op3_d = pc;
        op4_d = FOUR;
        if (illegal_in) begin
            op1_d = ZERO;
            op2_d = ir;             // Raw word for the trap value
        end else begin
            case (opcode)
                OP_LUI:   begin op1_d = ZERO; op2_d = immediate; end
                OP_AUIPC: op2_d = immediate;
                OP_JAL:   op4_d = immediate;
                OP_JALR:  begin op3_d = rd_port.rs1_data; op4_d = immediate; end
                OP_BR: begin
                    op1_d = rd_port.rs1_data;
                    op2_d = rd_port.rs2_data;
                    op4_d = immediate;  // Branch target offset
                end
                OP_LOAD, OP_OPIMM: begin op1_d = rd_port.rs1_data; op2_d = immediate; end
                OP_STORE: begin
                    op1_d = rd_port.rs1_data;
                    op2_d = immediate;
                    op3_d = ZERO;
                    op4_d = rd_port.rs2_data; // Store data through the adder
                end
                OP_OP:    begin op1_d = rd_port.rs1_data; op2_d = rd_port.rs2_data; end
                default:  ;
            endcase
        end
    end

    // --------------------------------------
    // Decoded payload, loaded on acceptance only
    always_ff @(posedge clk) begin
        if (accept) begin
            op1         <= op1_d;
            op2         <= op2_d;
            op3         <= op3_d;
            op4         <= op4_d;
            ex_ctrl     <= ex_ctrl_in;
            rd          <= rd_addr;
            rd_write    <= (rd_addr != '0) &&
                           (opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_OPIMM, OP_OP});
            branch      <= opcode inside {OP_JAL, OP_JALR};
            branch_cond <= (opcode == OP_BR);
            ld          <= (opcode == OP_LOAD);
            st          <= (opcode == OP_STORE);
            funct3      <= ir[14:12];   // Load/store size and sign
            is_illegal  <= illegal_in;
        end
    end

endmodule

// File: design/kronos_id.sv
// --------------------------------------
// Kronos RV32I instruction decode stage, top level
// --------------------------------------
`timescale 1ns/1ps

module kronos_id (
    input  logic                              clk,
    input  logic                              rstz,
    input  logic                              flush,
    input  logic [kronos_pkg::XLEN-1:0]       ir,
    input  logic [kronos_pkg::XLEN-1:0]       pc,
    input  logic                              in_valid,
    output logic                              in_ready,
    output logic [kronos_pkg::XLEN-1:0]       op1,
    output logic [kronos_pkg::XLEN-1:0]       op2,
    output logic [kronos_pkg::XLEN-1:0]       op3,
    output logic [kronos_pkg::XLEN-1:0]       op4,
    output logic                              cin,
    output logic                              rev,
    output logic                              uns,
    output logic                              eq,
    output logic                              inv,
    output logic                              align,
    output kronos_pkg::alu_sel_e              sel,
    output logic [kronos_pkg::REG_ADDR_W-1:0] rd,
    output logic                              rd_write,
    output logic                              branch,
    output logic                              branch_cond,
    output logic                              ld,
    output logic                              st,
    output logic [2:0]                        funct3,
    output logic                              is_illegal,
    output logic                              out_valid,
    input  logic                              out_ready,
    input  logic                              wr_en,
    input  logic [kronos_pkg::REG_ADDR_W-1:0] wr_sel,
    input  logic [kronos_pkg::XLEN-1:0]       wr_data
);
    import kronos_pkg::*;

    logic [XLEN-1:0] immediate;
    ex_ctrl_t        ex_ctrl_dec;   // Combinational decode
    ex_ctrl_t        ex_ctrl_q;     // Registered copy
    logic            illegal_dec;

    rf_read_if rf_rd ();

    kronos_regfile u_regfile (
        .clk    (clk),
        .rd_port(rf_rd.regfile),
        .wr_en  (wr_en),
        .wr_sel (wr_sel),
        .wr_data(wr_data)
    );

    kronos_imm_decode u_imm_decode (.ir(ir), .immediate(immediate));

    kronos_ex_decode u_ex_decode (
        .ir        (ir),
        .ex_ctrl   (ex_ctrl_dec),
        .is_illegal(illegal_dec)
    );

    kronos_id_ctrl u_ctrl (
        .clk        (clk),
        .rstz       (rstz),
        .flush      (flush),
        .ir         (ir),
        .pc         (pc),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .rd_port    (rf_rd.requester),
        .immediate  (immediate),
        .ex_ctrl_in (ex_ctrl_dec),
        .illegal_in (illegal_dec),
        .op1        (op1),
        .op2        (op2),
        .op3        (op3),
        .op4        (op4),
        .ex_ctrl    (ex_ctrl_q),
        .rd         (rd),
        .rd_write   (rd_write),
        .branch     (branch),
        .branch_cond(branch_cond),
        .ld         (ld),
        .st         (st),
        .funct3     (funct3),
        .is_illegal (is_illegal),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    // Struct fields out to flat ports
    assign cin   = ex_ctrl_q.cin;
    assign rev   = ex_ctrl_q.rev;
    assign uns   = ex_ctrl_q.uns;
    assign eq    = ex_ctrl_q.eq;
    assign inv   = ex_ctrl_q.inv;
    assign align = ex_ctrl_q.align;
    assign sel   = ex_ctrl_q.sel;

endmodule

// File: tb/kronos_id_tasks.svh
// --------------------------------------
// ID stage directed tests and RV32I encoders
// --------------------------------------
`ifndef KRONOS_ID_TASKS_SVH
`define KRONOS_ID_TASKS_SVH

// --------------------------------------
// Instruction encoders, standard RV32I layouts

function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd_idx);
    return {f7, rs2, rs1, f3, rd_idx, OP_OP, 2'b11};
endfunction

function automatic logic [XLEN-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd_idx,
                                          input opcode_e opc);
    return {imm, rs1, f3, rd_idx, opc, 2'b11};
endfunction

function automatic logic [XLEN-1:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE, 2'b11};
endfunction

function automatic logic [XLEN-1:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR, 2'b11};
endfunction

function automatic logic [XLEN-1:0] enc_u(input logic [19:0] imm, input logic [4:0] rd_idx,
                                          input opcode_e opc);
    return {imm, rd_idx, opc, 2'b11};
endfunction

function automatic logic [XLEN-1:0] enc_j(input logic [20:0] imm, input logic [4:0] rd_idx);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd_idx, OP_JAL, 2'b11};
endfunction

// Flags in order cin, rev, uns, eq, inv, align
function automatic ex_ctrl_t ctrl_of(input logic [5:0] flags, input alu_sel_e sel_e);
    return ex_ctrl_t'({flags, sel_e});
endfunction

function automatic ex_ctrl_t branch_ctrl(input logic [2:0] f3);
    logic eq_e, cin_e, uns_e, inv_e;
    eq_e  = (f3 == 3'd0) || (f3 == 3'd1);   // BEQ, BNE
    cin_e = f3 inside {3'd4, 3'd5, 3'd6, 3'd7};
    uns_e = (f3 == 3'd6) || (f3 == 3'd7);   // BLTU, BGEU
    inv_e = f3 inside {3'd1, 3'd5, 3'd7};
    return ctrl_of({cin_e, 1'b0, uns_e, eq_e, inv_e, 1'b0}, ALU_COMP);
endfunction

task automatic run_instr(input logic [XLEN-1:0] word);
    pc_val = $urandom & 32'hFFFF_FFFC;
    offer_instr(word, pc_val);
    wait_out_valid();
endtask

// --------------------------------------
// Directed tests

task automatic test_reset();
    start_test("reset");
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("in_ready", 1'b1, in_ready);
    end_test();
endtask

task automatic check_rr(input string what, input logic [XLEN-1:0] word, exp_op1,
                        input logic exp_wr, input ex_ctrl_t exp_ctrl);
    run_instr(word);
    check_word({what, " op1"}, exp_op1, op1);
    check_word({what, " op2"}, x2_val, op2);
    check_ctrl({what, " ctrl"}, exp_ctrl, act_ctrl);
    check_bit({what, " rd_write"}, exp_wr, rd_write);
endtask

task automatic test_reg_alu();
    start_test("reg_alu");
    x1_val = $urandom;
    x2_val = $urandom;
    write_reg(5'd1, x1_val);
    write_reg(5'd2, x2_val);
    check_rr("add", enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd5), x1_val, 1'b1,
             ctrl_of(6'b000000, ALU_ADDER));
    check_rr("sub", enc_r(7'd32, 5'd2, 5'd1, 3'd0, 5'd5), x1_val, 1'b1,
             ctrl_of(6'b100000, ALU_ADDER));
    check_rr("sltu", enc_r(7'd0, 5'd2, 5'd1, 3'd3, 5'd5), x1_val, 1'b1,
             ctrl_of(6'b101000, ALU_COMP));
    check_rr("sll", enc_r(7'd0, 5'd2, 5'd1, 3'd1, 5'd5), x1_val, 1'b1,
             ctrl_of(6'b011000, ALU_SHIFT));
    check_rr("xor", enc_r(7'd0, 5'd2, 5'd1, 3'd4, 5'd5), x1_val, 1'b1,
             ctrl_of(6'b000000, ALU_XOR));
    check_rr("rs1_x0", enc_r(7'd0, 5'd2, 5'd0, 3'd0, 5'd5), ZERO, 1'b1,
             ctrl_of(6'b000000, ALU_ADDER));
    check_rr("rd_x0", enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0), x1_val, 1'b0,
             ctrl_of(6'b000000, ALU_ADDER));
    end_test();
endtask

task automatic test_immediates();
    logic [11:0]     imm12;
    logic [19:0]     imm20;
    logic [20:0]     imm21;
    logic [XLEN-1:0] exp_imm;
    start_test("immediates");
    imm12   = 12'($urandom) | 12'h800;          // Negative I-immediate
    exp_imm = {{20{imm12[11]}}, imm12};
    run_instr(enc_i(imm12, 5'd1, 3'd0, 5'd3, OP_OPIMM));
    check_word("addi op1", x1_val, op1);
    check_word("addi op2", exp_imm, op2);
    check_ctrl("addi ctrl", ctrl_of(6'b000000, ALU_ADDER), act_ctrl);
    check_word("addi rd", 32'd3, rd);
    imm20   = 20'($urandom);
    exp_imm = {imm20, 12'h000};
    run_instr(enc_u(imm20, 5'd4, OP_LUI));
    check_word("lui op1", ZERO, op1);
    check_word("lui op2", exp_imm, op2);
    run_instr(enc_u(imm20, 5'd4, OP_AUIPC));
    check_word("auipc op1", pc_val, op1);
    check_word("auipc op2", exp_imm, op2);
    imm12   = 12'($urandom);
    exp_imm = {{20{imm12[11]}}, imm12};
    run_instr(enc_i(imm12, 5'd1, 3'd2, 5'd3, OP_LOAD));   // LW
    check_word("lw op1", x1_val, op1);
    check_word("lw op2", exp_imm, op2);
    check_word("lw rd", 32'd3, rd);
    check_word("lw funct3", 32'd2, funct3);
    check_bit("lw ld", 1'b1, ld);
    check_bit("lw rd_write", 1'b0, rd_write);
    imm12   = 12'($urandom);
    exp_imm = {{20{imm12[11]}}, imm12};
    run_instr(enc_s(imm12, 5'd2, 5'd1, 3'd2));   // SW
    check_word("sw op2", exp_imm, op2);
    check_word("sw op3", ZERO, op3);
    check_word("sw op4", x2_val, op4);
    check_bit("sw st", 1'b1, st);
    check_bit("sw ld", 1'b0, ld);
    check_bit("sw rd_write", 1'b0, rd_write);
    imm21   = {20'($urandom), 1'b0};            // Jump offsets are even
    exp_imm = {{11{imm21[20]}}, imm21};
    run_instr(enc_j(imm21, 5'd1));
    check_word("jal op1", pc_val, op1);
    check_word("jal op2", FOUR, op2);
    check_word("jal op4", exp_imm, op4);
    check_bit("jal branch", 1'b1, branch);
    end_test();
endtask

task automatic test_branches();
    logic [2:0]  f3s [6];
    logic [12:0] imm13;
    logic [11:0] imm12;
    start_test("branches");
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    foreach (f3s[i]) begin
        imm13 = {12'($urandom), 1'b0};
        run_instr(enc_b(imm13, 5'd2, 5'd1, f3s[i]));
        check_ctrl($sformatf("br%0d ctrl", f3s[i]), branch_ctrl(f3s[i]), act_ctrl);
        check_word("br op1", x1_val, op1);
        check_word("br op2", x2_val, op2);
        check_word("br op3", pc_val, op3);
        check_word("br op4", {{19{imm13[12]}}, imm13}, op4);
        check_bit("br branch_cond", 1'b1, branch_cond);
    end
    imm12 = 12'($urandom);
    run_instr(enc_i(imm12, 5'd1, 3'd0, 5'd6, OP_JALR));
    check_ctrl("jalr ctrl", ctrl_of(6'b000001, ALU_ADDER), act_ctrl);
    check_bit("jalr branch", 1'b1, branch);
    check_word("jalr op3", x1_val, op3);
    check_word("jalr op4", {{20{imm12[11]}}, imm12}, op4);
    end_test();
endtask

task automatic test_illegal();
    logic [XLEN-1:0] words [4];
    start_test("illegal");
    words = '{32'h0000_0011,                         // ADDI with low bits 01
              32'h0000_0073,                         // ECALL
              32'h0FF0_000F,                         // FENCE
              enc_r(7'd1, 5'd2, 5'd1, 3'd0, 5'd5)};  // MUL, no M extension
    foreach (words[i]) begin
        run_instr(words[i]);
        check_bit($sformatf("word%0d is_illegal", i), 1'b1, is_illegal);
        check_word($sformatf("word%0d op1", i), ZERO, op1);
        check_word($sformatf("word%0d op2", i), words[i], op2);
    end
    end_test();
endtask

task automatic test_backpressure();
    logic [XLEN-1:0] word_a, word_b;
    start_test("backpressure");
    word_a    = enc_i(12'd5, 5'd1, 3'd0, 5'd7, OP_OPIMM);
    word_b    = enc_i(12'd9, 5'd1, 3'd0, 5'd8, OP_OPIMM);
    @(posedge clk);                     // Previous result drains
    #1;
    out_ready = 1'b0;
    run_instr(word_a);
    ir       = word_b;                  // Second offer stalls behind A
    in_valid = 1'b1;
    repeat (3) begin
        @(posedge clk);
        #1;
        check_bit("held out_valid", 1'b1, out_valid);
        check_bit("held in_ready", 1'b0, in_ready);
        check_word("held op2", 32'd5, op2);
    end
    out_ready = 1'b1;
    @(posedge clk);                     // A drains, B loads
    #1;
    in_valid = 1'b0;
    check_bit("b2b out_valid", 1'b1, out_valid);
    check_word("b2b op2", 32'd9, op2);
    @(posedge clk);
    #1;
    check_bit("drained out_valid", 1'b0, out_valid);

    // --------------------------------------
    // Flush drops the held result and the new offer
    out_ready = 1'b0;
    run_instr(word_a);
    out_ready = 1'b1;
    ir        = word_b;
    in_valid  = 1'b1;
    flush     = 1'b1;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    flush    = 1'b0;
    repeat (3) begin
        check_bit("flush out_valid", 1'b0, out_valid);
        @(posedge clk);
        #1;
    end
    end_test();
endtask

`endif

// File: tb/kronos_id_tb.sv
// --------------------------------------
// Directed testbench for the Kronos ID stage
// --------------------------------------
`timescale 1ns/1ps

module kronos_id_tb;
    import kronos_pkg::*;

    logic                  clk;
    logic                  rstz;
    logic                  flush;
    logic [XLEN-1:0]       ir;
    logic [XLEN-1:0]       pc;
    logic                  in_valid;
    logic                  in_ready;
    logic [XLEN-1:0]       op1, op2, op3, op4;
    logic                  cin, rev, uns, eq, inv, align;
    alu_sel_e              sel;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_write, branch, branch_cond, ld, st;
    logic [2:0]            funct3;
    logic                  is_illegal;
    logic                  out_valid;
    logic                  out_ready;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_sel;
    logic [XLEN-1:0]       wr_data;
    ex_ctrl_t              act_ctrl;        // Flat control ports regrouped

    // Per-test bookkeeping
    string                 test_name;
    int                    test_errs;
    int                    tests_passed;
    int                    tests_failed;
    logic [XLEN-1:0]       x1_val, x2_val;  // Known contents of x1, x2
    logic [XLEN-1:0]       pc_val;          // PC of the last instruction

    kronos_id dut (.*);

    assign act_ctrl = ex_ctrl_t'({cin, rev, uns, eq, inv, align, sel});

    always #4 clk = ~clk; // 8 ns period

    // --------------------------------------
    // Compare tasks

    task automatic check_word(input string what, input logic [XLEN-1:0] exp, act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_ctrl(input string what, input ex_ctrl_t exp, act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("ok   %s", test_name);
            tests_passed++;
        end else begin
            $display("FAIL %s, %0d errors", test_name, test_errs);
            tests_failed++;
        end
    endtask

    // --------------------------------------
    // Bus helpers, inputs change 1 ns after the edge

    task automatic write_reg(input logic [REG_ADDR_W-1:0] idx, input logic [XLEN-1:0] value);
        wr_en   = 1'b1;
        wr_sel  = idx;
        wr_data = value;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic offer_instr(input logic [XLEN-1:0] word, input logic [XLEN-1:0] addr);
        int cycles;
        ir       = word;
        pc       = addr;
        in_valid = 1'b1;
        cycles   = 0;
        while (!in_ready && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!in_ready) begin
            $display("Timeout in %s: the stage never became ready", test_name);
            test_errs++;
        end else begin
            @(posedge clk);     // Accepting edge
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_out_valid();
        int cycles;
        cycles = 0;
        while (!out_valid && cycles < 100) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!out_valid) begin
            $display("Timeout in %s: no decoded result came out", test_name);
            test_errs++;
        end
    endtask

    `include "kronos_id_tasks.svh"

    // --------------------------------------
    // Test sequence
    initial begin
        void'($urandom(39));
        clk          = 1'b0;
        rstz         = 1'b0;
        flush        = 1'b0;
        ir           = '0;
        pc           = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        wr_en        = 1'b0;
        wr_sel       = '0;
        wr_data      = '0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        #1;
        rstz = 1'b1;

        test_reset();
        test_reg_alu();
        test_immediates();
        test_branches();
        test_illegal();
        test_backpressure();

        $display("Summary: %0d tests ok, %0d tests failing", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: kronos_id.f
+incdir+tb
design/kronos_pkg.sv
design/rf_read_if.sv
design/kronos_regfile.sv
design/kronos_imm_decode.sv
design/kronos_ex_decode.sv
design/kronos_id_ctrl.sv
design/kronos_id.sv
tb/kronos_id_tb.sv
